//--- design/buffer_arbiter.sv
`timescale 1ns/1ps

module buffer_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    // scanner, read only
    input  logic                      scan_req,
    input  dot_matrix_pkg::row_idx_t  scan_row,
    output dot_matrix_pkg::col_bits_t scan_red,
    output dot_matrix_pkg::col_bits_t scan_green,
    // host strobe, no back-pressure
    input  logic                      pix_we,
    input  dot_matrix_pkg::row_idx_t  pix_row,
    input  dot_matrix_pkg::col_bits_t pix_red,
    input  dot_matrix_pkg::col_bits_t pix_green,
    // painter, held request
    input  logic                      paint_req,
    input  dot_matrix_pkg::row_idx_t  paint_row,
    input  dot_matrix_pkg::col_bits_t paint_red,
    input  dot_matrix_pkg::col_bits_t paint_green,
    output logic                      paint_gnt,
    // frame buffer port
    output logic                      buf_en,
    output logic                      buf_we,
    output dot_matrix_pkg::row_idx_t  buf_row,
    output dot_matrix_pkg::col_bits_t buf_wred,
    output dot_matrix_pkg::col_bits_t buf_wgreen,
    input  dot_matrix_pkg::col_bits_t buf_rred,
    input  dot_matrix_pkg::col_bits_t buf_rgreen
);
    import dot_matrix_pkg::*;

    logic      pend_valid;
    row_idx_t  pend_row;
    col_bits_t pend_red;
    col_bits_t pend_green;

    logic      scan_gnt;
    logic      host_gnt;

    // host slot, a newer strobe overwrites a waiting one
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pend_valid <= 1'b0;
        else if (pix_we)
            pend_valid <= 1'b1;
        else if (host_gnt)
            pend_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (pix_we)
        begin
            pend_row   <= pix_row;
            pend_red   <= pix_red;
            pend_green <= pix_green;
        end
    end

    // fixed priority: scanner, host, painter
    always_comb
    begin
        scan_gnt  = 1'b0;
        host_gnt  = 1'b0;
        paint_gnt = 1'b0;
        if (scan_req)
            scan_gnt = 1'b1;
        else if (pend_valid)
            host_gnt = 1'b1;
        else if (paint_req)
            paint_gnt = 1'b1;
    end

    assign buf_en     = scan_gnt | host_gnt | paint_gnt;
    assign buf_we     = host_gnt | paint_gnt;
    assign buf_row    = scan_gnt ? scan_row : (host_gnt ? pend_row : paint_row);
    assign buf_wred   = host_gnt ? pend_red : paint_red;
    assign buf_wgreen = host_gnt ? pend_green : paint_green;

    // only the scanner reads, so read data goes straight back to it
    assign scan_red   = buf_rred;
    assign scan_green = buf_rgreen;

endmodule

//--- design/dot_matrix_pkg.sv
package dot_matrix_pkg;

    // matrix geometry
    localparam int num_rows = 8;

    // row number 0..7
    typedef logic [2:0] row_idx_t;

    // one bit per column, bit 7 is the leftmost LED
    typedef logic [7:0] col_bits_t;

    // active-low row select lines
    typedef logic [7:0] row_lines_t;

    localparam row_lines_t rows_off = 8'hff; // no row lit

endpackage

//--- design/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      en,
    input  logic                      we,
    input  dot_matrix_pkg::row_idx_t  addr,
    input  dot_matrix_pkg::col_bits_t wred,
    input  dot_matrix_pkg::col_bits_t wgreen,
    output dot_matrix_pkg::col_bits_t rred,
    output dot_matrix_pkg::col_bits_t rgreen
);
    import dot_matrix_pkg::*;

    col_bits_t mem_red   [num_rows];
    col_bits_t mem_green [num_rows];

    // write port
    always_ff @(posedge clk)
    begin
        if (en && we)
        begin
            mem_red[addr]   <= wred;
            mem_green[addr] <= wgreen;
        end
    end

    // registered read, data valid the cycle after en
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rred   <= '0;
            rgreen <= '0;
        end
        else if (en && !we)
        begin
            rred   <= mem_red[addr];
            rgreen <= mem_green[addr];
        end
    end

endmodule

//--- design/matrix_display_top.sv
`timescale 1ns/1ps

module matrix_display_top #(
    parameter int scan_div = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       shape_stb,
    input  shape_pkg::shape_level_t    shape_level,
    input  shape_pkg::color_t          shape_color,
    input  logic                       pix_we,
    input  dot_matrix_pkg::row_idx_t   pix_row,
    input  dot_matrix_pkg::col_bits_t  pix_red,
    input  dot_matrix_pkg::col_bits_t  pix_green,
    output dot_matrix_pkg::row_lines_t row,
    output dot_matrix_pkg::col_bits_t  colr,
    output dot_matrix_pkg::col_bits_t  colg,
    output logic                       painter_busy
);
    import dot_matrix_pkg::*;

    logic      scan_req;
    row_idx_t  scan_row;
    col_bits_t scan_red;
    col_bits_t scan_green;

    logic      paint_req;
    logic      paint_gnt;
    row_idx_t  paint_row;
    col_bits_t paint_red;
    col_bits_t paint_green;

    logic      buf_en;
    logic      buf_we;
    row_idx_t  buf_row;
    col_bits_t buf_wred;
    col_bits_t buf_wgreen;
    col_bits_t buf_rred;
    col_bits_t buf_rgreen;

    frame_buffer u_frame_buffer (
        .clk    (clk),
        .rst    (rst),
        .en     (buf_en),
        .we     (buf_we),
        .addr   (buf_row),
        .wred   (buf_wred),
        .wgreen (buf_wgreen),
        .rred   (buf_rred),
        .rgreen (buf_rgreen)
    );

    buffer_arbiter u_buffer_arbiter (
        .clk         (clk),
        .rst         (rst),
        .scan_req    (scan_req),
        .scan_row    (scan_row),
        .scan_red    (scan_red),
        .scan_green  (scan_green),
        .pix_we      (pix_we),
        .pix_row     (pix_row),
        .pix_red     (pix_red),
        .pix_green   (pix_green),
        .paint_req   (paint_req),
        .paint_row   (paint_row),
        .paint_red   (paint_red),
        .paint_green (paint_green),
        .paint_gnt   (paint_gnt),
        .buf_en      (buf_en),
        .buf_we      (buf_we),
        .buf_row     (buf_row),
        .buf_wred    (buf_wred),
        .buf_wgreen  (buf_wgreen),
        .buf_rred    (buf_rred),
        .buf_rgreen  (buf_rgreen)
    );

    shape_painter u_shape_painter (
        .clk          (clk),
        .rst          (rst),
        .shape_stb    (shape_stb),
        .shape_level  (shape_level),
        .shape_color  (shape_color),
        .painter_busy (painter_busy),
        .paint_req    (paint_req),
        .paint_row    (paint_row),
        .paint_red    (paint_red),
        .paint_green  (paint_green),
        .paint_gnt    (paint_gnt)
    );

    row_scanner #(
        .scan_div (scan_div)
    ) u_row_scanner (
        .clk        (clk),
        .rst        (rst),
        .scan_req   (scan_req),
        .scan_row   (scan_row),
        .scan_red   (scan_red),
        .scan_green (scan_green),
        .row        (row),
        .colr       (colr),
        .colg       (colg)
    );

endmodule

//--- design/row_scanner.sv
`timescale 1ns/1ps

module row_scanner #(
    parameter int scan_div = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    output logic                       scan_req,
    output dot_matrix_pkg::row_idx_t   scan_row,
    input  dot_matrix_pkg::col_bits_t  scan_red,
    input  dot_matrix_pkg::col_bits_t  scan_green,
    output dot_matrix_pkg::row_lines_t row,
    output dot_matrix_pkg::col_bits_t  colr,
    output dot_matrix_pkg::col_bits_t  colg
);
    import dot_matrix_pkg::*;

    localparam int             div_w    = $clog2(scan_div);
    localparam logic [div_w-1:0] div_last = div_w'(scan_div - 1);

    logic [div_w-1:0] div_cnt;
    logic             tick;
    logic             rd_pend;  // read data arrives this cycle
    row_idx_t         row_cnt;
    row_idx_t         next_row;

    assign tick     = (div_cnt == div_last);
    assign next_row = (row_cnt == row_idx_t'(num_rows - 1)) ? '0 : row_cnt + 1'b1;

    // one pulse per row period, granted in the same cycle
    assign scan_req = tick;
    assign scan_row = next_row;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            row_cnt <= row_idx_t'(num_rows - 1); // first tick reads row 0
            rd_pend <= 1'b0;
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            rd_pend <= tick;
            if (tick)
                row_cnt <= next_row;
        end
    end

    // row and columns switch together, two clocks after the tick
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= rows_off;
            colr <= '0;
            colg <= '0;
        end
        else if (rd_pend)
        begin
            row  <= ~(row_lines_t'(1) << row_cnt);
            colr <= scan_red;
            colg <= scan_green;
        end
    end

endmodule

//--- design/shape_painter.sv
`timescale 1ns/1ps

module shape_painter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      shape_stb,
    input  shape_pkg::shape_level_t   shape_level,
    input  shape_pkg::color_t         shape_color,
    output logic                      painter_busy,
    output logic                      paint_req,
    output dot_matrix_pkg::row_idx_t  paint_row,
    output dot_matrix_pkg::col_bits_t paint_red,
    output dot_matrix_pkg::col_bits_t paint_green,
    input  logic                      paint_gnt
);
    import dot_matrix_pkg::*;
    import shape_pkg::*;

    typedef enum logic
    {
        st_idle,
        st_paint
    } state_t;

    state_t       state;
    logic         start;
    logic         last_row;
    row_idx_t     row_cnt;
    shape_level_t level_q;
    color_t       color_q;
    col_bits_t    pattern;

    assign start    = shape_stb && (state == st_idle); // dropped while busy
    assign last_row = (row_cnt == row_idx_t'(num_rows - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= st_idle;
            row_cnt <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (start)
                    begin
                        state   <= st_paint;
                        row_cnt <= '0;
                    end
                end
                st_paint:
                begin
                    // one row per grant, done after row 7
                    if (paint_gnt)
                    begin
                        if (last_row)
                            state <= st_idle;
                        else
                            row_cnt <= row_cnt + 1'b1;
                    end
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // command held for the whole fill
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            level_q <= shape_level;
            color_q <= shape_color;
        end
    end

    assign pattern = shape_row_bits(level_q, row_cnt);

    assign painter_busy = (state == st_paint);
    assign paint_req    = painter_busy;  // held until granted
    assign paint_row    = row_cnt;
    assign paint_red    = color_q[color_red_bit]   ? pattern : '0;
    assign paint_green  = color_q[color_green_bit] ? pattern : '0;

endmodule

//--- design/shape_pkg.sv
package shape_pkg;

    // 1..4 draw a block, other values give a blank frame
    typedef logic [2:0] shape_level_t;

    // bit 0 red, bit 1 green
    typedef logic [1:0] color_t;

    localparam int color_red_bit   = 0;
    localparam int color_green_bit = 1;

    // column byte of a centred block, by size level and row
    function automatic dot_matrix_pkg::col_bits_t shape_row_bits(
        input shape_level_t              level,
        input dot_matrix_pkg::row_idx_t  r
    );
        dot_matrix_pkg::col_bits_t bits;
        bits = 8'h00;
        case (level)
            3'd1:
            begin
                if (r == 3'd0 || r == 3'd5)
                    bits = 8'h3c;
                else if (r >= 3'd1 && r <= 3'd4)
                    bits = 8'h7e;
            end
            3'd2:
            begin
                if (r == 3'd1 || r == 3'd4)
                    bits = 8'h3c;
                else if (r == 3'd2 || r == 3'd3)
                    bits = 8'h7e;
            end
            3'd3:
            begin
                if (r == 3'd1 || r == 3'd4)
                    bits = 8'h38; // off centre by one column
                else if (r == 3'd2 || r == 3'd3)
                    bits = 8'h7c;
            end
            3'd4:
            begin
                if (r == 3'd1 || r == 3'd4)
                    bits = 8'h18;
                else if (r == 3'd2 || r == 3'd3)
                    bits = 8'h3c;
            end
            default:
                bits = 8'h00; // blank frame
        endcase
        return bits;
    endfunction

endpackage

//--- filelist.f
design/dot_matrix_pkg.sv
design/shape_pkg.sv
design/frame_buffer.sv
design/buffer_arbiter.sv
design/shape_painter.sv
design/row_scanner.sv
design/matrix_display_top.sv
sim/matrix_display_sva.sv
sim/matrix_display_tb.sv

//--- sim/matrix_display_sva.sv
`timescale 1ns/1ps

module matrix_display_sva (
    input logic                       clk,
    input logic                       rst,
    input dot_matrix_pkg::row_lines_t row,
    input dot_matrix_pkg::col_bits_t  colr,
    input dot_matrix_pkg::col_bits_t  colg,
    input logic                       scan_gnt,
    input logic                       host_gnt,
    input logic                       paint_gnt
);
    import dot_matrix_pkg::*;

    // never more than one row driven low
    row_single_low: assert property (@(posedge clk) disable iff (rst) $onehot0(~row))
        else $error("row lines %h select more than one row", row);

    dark_columns: assert property (@(posedge clk) disable iff (rst)
        (row == rows_off) |-> (colr == '0 && colg == '0))
        else $error("columns %h/%h driven with no row lit", colr, colg);

    // one client on the buffer port per cycle
    single_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0({scan_gnt, host_gnt, paint_gnt}))
        else $error("grants scan=%b host=%b paint=%b overlap", scan_gnt, host_gnt, paint_gnt);

endmodule

// scanner instance watches the outputs only
bind row_scanner matrix_display_sva u_scanner_sva (
    .clk       (clk),
    .rst       (rst),
    .row       (row),
    .colr      (colr),
    .colg      (colg),
    .scan_gnt  (1'b0),
    .host_gnt  (1'b0),
    .paint_gnt (1'b0)
);

bind buffer_arbiter matrix_display_sva u_arbiter_sva (
    .clk       (clk),
    .rst       (rst),
    .row       (8'hff),
    .colr      (8'h00),
    .colg      (8'h00),
    .scan_gnt  (scan_gnt),
    .host_gnt  (host_gnt),
    .paint_gnt (paint_gnt)
);

//--- sim/matrix_display_tb.sv
`timescale 1ns/1ps

module matrix_display_tb;
    import dot_matrix_pkg::*;
    import shape_pkg::*;

    localparam int scan_div        = 8;
    localparam int num_cases       = 21; // reset check plus every frame check
    localparam int watchdog_cycles = num_cases * 3 * num_rows * scan_div + 200;
    localparam int settle_cycles   = scan_div + 5;
    localparam int busy_limit      = num_rows * scan_div;

    logic         clk;
    logic         rst;
    logic         shape_stb;
    shape_level_t shape_level;
    color_t       shape_color;
    logic         pix_we;
    row_idx_t     pix_row;
    col_bits_t    pix_red;
    col_bits_t    pix_green;
    row_lines_t   row;
    col_bits_t    colr;
    col_bits_t    colg;
    logic         painter_busy;

    col_bits_t model_red   [num_rows];
    col_bits_t model_green [num_rows];
    int        value_errors;
    int        other_errors;
    integer    seed;

    matrix_display_top #(
        .scan_div (scan_div)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .shape_stb    (shape_stb),
        .shape_level  (shape_level),
        .shape_color  (shape_color),
        .pix_we       (pix_we),
        .pix_row      (pix_row),
        .pix_red      (pix_red),
        .pix_green    (pix_green),
        .row          (row),
        .colr         (colr),
        .colg         (colg),
        .painter_busy (painter_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected)
        begin
            value_errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // block table with row 0 in the top byte
    function automatic col_bits_t expected_pattern(input shape_level_t level, input row_idx_t r);
        logic [63:0] rows_msb_first;
        case (level)
            3'd1:    rows_msb_first = 64'h3c7e_7e7e_7e3c_0000;
            3'd2:    rows_msb_first = 64'h003c_7e7e_3c00_0000;
            3'd3:    rows_msb_first = 64'h0038_7c7c_3800_0000;
            3'd4:    rows_msb_first = 64'h0018_3c3c_1800_0000;
            default: rows_msb_first = '0;
        endcase
        return rows_msb_first[63 - 8 * r -: 8];
    endfunction

    // index of the single low row line or -1
    function automatic int lit_row(input row_lines_t lines);
        int zeros;
        int idx;
        zeros = 0;
        idx   = -1;
        for (int k = 0; k < num_rows; k++)
        begin
            if (lines[k] == 1'b0)
            begin
                zeros++;
                idx = k;
            end
        end
        return (zeros == 1) ? idx : -1;
    endfunction

    task automatic shape_model(input shape_level_t level, input color_t color);
        for (int r = 0; r < num_rows; r++)
        begin
            model_red[r]   = color[0] ? expected_pattern(level, row_idx_t'(r)) : 8'h00;
            model_green[r] = color[1] ? expected_pattern(level, row_idx_t'(r)) : 8'h00;
        end
    endtask

    task automatic host_write(input row_idx_t r, input col_bits_t red, input col_bits_t green);
        @(posedge clk);
        pix_we    <= 1'b1;
        pix_row   <= r;
        pix_red   <= red;
        pix_green <= green;
        @(posedge clk);
        pix_we <= 1'b0;
        repeat (2) @(posedge clk); // slot drained even behind a scan read
        model_red[r]   = red;
        model_green[r] = green;
    endtask

    task automatic start_shape(input shape_level_t level, input color_t color);
        @(posedge clk);
        shape_stb   <= 1'b1;
        shape_level <= level;
        shape_color <= color;
        @(posedge clk);
        shape_stb <= 1'b0;
    endtask

    task automatic wait_painter_idle();
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (painter_busy && n < busy_limit);
        if (painter_busy)
        begin
            other_errors++;
            $display("painter still busy after %0d cycles", busy_limit);
        end
    endtask

    task automatic paint_shape(input shape_level_t level, input color_t color);
        start_shape(level, color);
        @(negedge clk);
        check("painter_busy", painter_busy, 1);
        wait_painter_idle();
        shape_model(level, color);
    endtask

    // let stale rows scroll out then watch one full frame
    task automatic scan_frame();
        row_lines_t seen;
        int         i;
        seen = '0;
        repeat (settle_cycles) @(posedge clk);
        repeat (num_rows * scan_div)
        begin
            @(negedge clk);
            i = lit_row(row);
            if (i >= 0)
            begin
                seen[i] = 1'b1;
                check($sformatf("colr row %0d", i), colr, model_red[i]);
                check($sformatf("colg row %0d", i), colg, model_green[i]);
            end
        end
        if (seen != 8'hff)
        begin
            other_errors++;
            $display("frame check saw only rows %b lit", seen);
        end
    endtask

    task automatic idle_after_reset();
        int n;
        repeat (scan_div)
        begin
            @(negedge clk);
            check("row", row, 32'hff);
            check("colr", colr, 0);
            check("colg", colg, 0);
            check("painter_busy", painter_busy, 0);
        end
        n = 0;
        while (row === rows_off && n < scan_div)
        begin
            @(negedge clk);
            n++;
        end
        if (row === rows_off)
        begin
            other_errors++;
            $display("no row was lit after the first row tick");
        end
    endtask

    task automatic host_rows_frame();
        col_bits_t first_red;
        col_bits_t first_green;
        for (int r = 0; r < num_rows; r++)
            host_write(row_idx_t'(r), col_bits_t'($random(seed)), col_bits_t'($random(seed)));
        first_red   = col_bits_t'($random(seed));
        first_green = col_bits_t'($random(seed));
        @(posedge clk);
        pix_we    <= 1'b1;
        pix_row   <= 3'd5;
        pix_red   <= first_red;
        pix_green <= first_green;
        model_red[5]   = col_bits_t'($random(seed));
        model_green[5] = col_bits_t'($random(seed));
        @(posedge clk);
        pix_red   <= model_red[5];  // back to back on the same row
        pix_green <= model_green[5];
        @(posedge clk);
        pix_we <= 1'b0;
        scan_frame();
    endtask

    task automatic sizes_and_colors();
        for (int lvl = 1; lvl <= 4; lvl++)
        begin
            for (int c = 1; c <= 3; c++)
            begin
                paint_shape(shape_level_t'(lvl), color_t'(c));
                scan_frame();
            end
        end
    endtask

    task automatic blank_shapes_clear();
        for (int lvl = 0; lvl < 8; lvl++)
        begin
            if (lvl == 0 || lvl >= 5)
            begin
                paint_shape(3'd1, 2'd3); // lit content to clear
                paint_shape(shape_level_t'(lvl), 2'd3);
                scan_frame();
            end
        end
        paint_shape(3'd1, 2'd3);
        paint_shape(3'd2, 2'd0); // dark colour
        scan_frame();
    endtask

    task automatic strobe_while_busy();
        start_shape(3'd4, 2'd1);
        @(negedge clk);
        check("painter_busy", painter_busy, 1);
        start_shape(3'd1, 2'd2); // dropped as the painter is still busy
        wait_painter_idle();
        shape_model(3'd4, 2'd1);
        @(negedge clk);
        check("painter_busy", painter_busy, 0);
        scan_frame();
    endtask

    task automatic host_over_shape();
        paint_shape(3'd2, 2'd3);
        host_write(3'd1, col_bits_t'($random(seed)), col_bits_t'($random(seed)));
        host_write(3'd4, col_bits_t'($random(seed)), col_bits_t'($random(seed)));
        host_write(3'd6, col_bits_t'($random(seed)), col_bits_t'($random(seed)));
        scan_frame();
    endtask

    initial
    begin
        seed         = 14134;
        value_errors = 0;
        other_errors = 0;
        rst          = 1'b1;
        shape_stb    = 1'b0;
        shape_level  = '0;
        shape_color  = '0;
        pix_we       = 1'b0;
        pix_row      = '0;
        pix_red      = '0;
        pix_green    = '0;
        for (int r = 0; r < num_rows; r++)
        begin
            model_red[r]   = '0;
            model_green[r] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        host_rows_frame();
        sizes_and_colors();
        blank_shapes_clear();
        strobe_while_busy();
        host_over_shape();
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: tests still running after %0d clock cycles", watchdog_cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule
